//--- design/uart_hub_pkg.sv
package uart_hub_pkg;

  // channel count and address map
  localparam int N_CHANNELS = 4;
  localparam int CH_SEL_LO  = 4;              // slot field starts at byte address bit 4
  localparam int CH_SEL_W   = 3;              // 8 slots, only the low ones mapped

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // start + 8 data + parity + 2 stop
  localparam int FRAME_BITS = 12;
  localparam int BIT_CNT_W  = $clog2(FRAME_BITS);

  localparam int DIVIDER_W = 16;
  localparam logic [DIVIDER_W-1:0] DEFAULT_DIVIDER = 16'd5050;

  // register offset, word address bits [3:2]
  typedef enum logic [1:0] {
    REG_DATA    = 2'd0,
    REG_DIVIDER = 2'd1,
    REG_NONE    = 2'd2
  } reg_op_e;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_SEND,
    TX_DONE
  } tx_state_e;

endpackage

//--- design/wb_addr_decoder.sv
`timescale 1ns/1ns

module wb_addr_decoder (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   cyc_i,
  input  logic                                   stb_i,
  input  logic                                   we_i,
  input  logic [uart_hub_pkg::ADDR_W-1:0]        adr_i,
  input  logic [uart_hub_pkg::DATA_W-1:0]        wdata_i,
  input  logic                                   done_i,
  output logic [uart_hub_pkg::N_CHANNELS-1:0]    ch_req_o,
  output logic                                   ch_we_o,
  output uart_hub_pkg::reg_op_e                  ch_op_o,
  output logic [uart_hub_pkg::DATA_W-1:0]        ch_wdata_o,
  output logic                                   err_o
);

  import uart_hub_pkg::*;

  logic                busy_q;
  logic                accept;
  logic                mapped;
  logic [CH_SEL_W-1:0] slot;
  reg_op_e             op;

  assign slot   = adr_i[CH_SEL_LO +: CH_SEL_W];
  assign mapped = slot < N_CHANNELS;
  assign accept = cyc_i && stb_i && !busy_q;   // held stb ignored while busy

  always_comb
  begin
    case (adr_i[3:2])
      2'd0:    op = REG_DATA;
      2'd1:    op = REG_DIVIDER;
      default: op = REG_NONE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy_q   <= 1'b0;
      ch_req_o <= '0;
      err_o    <= 1'b0;
    end
    else
    begin
      ch_req_o <= '0;                          // pulses last one cycle
      err_o    <= 1'b0;
      if (done_i)
        busy_q <= 1'b0;
      if (accept)
      begin
        busy_q <= 1'b1;
        for (int i = 0; i < N_CHANNELS; i++)
          ch_req_o[i] <= mapped && (slot == i);
        err_o <= !mapped;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      ch_we_o    <= we_i;
      ch_op_o    <= op;
      ch_wdata_o <= wdata_i;
    end
  end

endmodule

//--- design/uart_tx_channel.sv
`timescale 1ns/1ns

module uart_tx_channel (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            req_i,
  input  logic                            we_i,
  input  uart_hub_pkg::reg_op_e           op_i,
  input  logic [uart_hub_pkg::DATA_W-1:0] wdata_i,
  output logic                            ack_o,
  output logic [uart_hub_pkg::DATA_W-1:0] rdata_o,
  output logic                            txd_o
);

  import uart_hub_pkg::*;

  tx_state_e             state_q;
  logic [DIVIDER_W-1:0]  divider_q;
  logic [DIVIDER_W-1:0]  baud_cnt_q;
  logic [BIT_CNT_W-1:0]  bit_cnt_q;
  logic [FRAME_BITS-1:0] frame_q;
  logic                  reg_ack_q;

  logic                  start_tx;
  logic                  reg_access;
  logic                  bit_end;
  logic                  last_bit;
  logic [7:0]            tx_byte;

  assign tx_byte = wdata_i[7:0];

  // a data write holds the ack until the frame is out
  assign start_tx   = req_i && we_i && (op_i == REG_DATA) && (state_q == TX_IDLE);
  assign reg_access = req_i && !(we_i && (op_i == REG_DATA));

  assign bit_end  = baud_cnt_q == divider_q;   // bit lasts divider+1 cycles
  assign last_bit = bit_cnt_q == BIT_CNT_W'(FRAME_BITS - 1);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q    <= TX_IDLE;
      baud_cnt_q <= '0;
      bit_cnt_q  <= '0;
      txd_o      <= 1'b1;                      // line idles high
      reg_ack_q  <= 1'b0;
      divider_q  <= DEFAULT_DIVIDER;
    end
    else
    begin
      reg_ack_q <= reg_access;
      if (reg_access && we_i && (op_i == REG_DIVIDER))
        divider_q <= wdata_i[DIVIDER_W-1:0];

      case (state_q)
        TX_IDLE:
        begin
          if (start_tx)
          begin
            state_q    <= TX_SEND;
            baud_cnt_q <= '0;
            bit_cnt_q  <= '0;
            txd_o      <= 1'b0;                // start bit
          end
        end
        TX_SEND:
        begin
          if (bit_end)
          begin
            baud_cnt_q <= '0;
            if (last_bit)
              state_q <= TX_DONE;              // second stop bit finished
            else
            begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
              txd_o     <= frame_q[1];
            end
          end
          else
            baud_cnt_q <= baud_cnt_q + 1'b1;
        end
        TX_DONE:
          state_q <= TX_IDLE;
        default:
          state_q <= TX_IDLE;
      endcase
    end
  end

  // frame shifts right, bit 0 is the one on the line
  always_ff @(posedge clk)
  begin
    if (start_tx)
      frame_q <= {2'b11, ^tx_byte, tx_byte, 1'b0};
    else if ((state_q == TX_SEND) && bit_end)
      frame_q <= {1'b1, frame_q[FRAME_BITS-1:1]};
  end

  always_ff @(posedge clk)
  begin
    rdata_o <= '0;
    if (reg_access && !we_i && (op_i == REG_DIVIDER))
      rdata_o <= {{(DATA_W - DIVIDER_W){1'b0}}, divider_q};
  end

  assign ack_o = reg_ack_q || (state_q == TX_DONE);

endmodule

//--- design/wb_rsp_mux.sv
`timescale 1ns/1ns

module wb_rsp_mux (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [uart_hub_pkg::N_CHANNELS-1:0] ch_ack_i,
  input  logic [uart_hub_pkg::DATA_W-1:0]     ch_rdata_i [uart_hub_pkg::N_CHANNELS],
  input  logic                                err_i,
  output logic                                ack_o,
  output logic                                err_o,
  output logic [uart_hub_pkg::DATA_W-1:0]     rdata_o
);

  import uart_hub_pkg::*;

  logic [DATA_W-1:0] rdata_merged;

  // only one channel acks at a time, so an AND-OR merge is enough
  always_comb
  begin
    rdata_merged = '0;
    for (int i = 0; i < N_CHANNELS; i++)
      rdata_merged = rdata_merged | (ch_rdata_i[i] & {DATA_W{ch_ack_i[i]}});
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ack_o   <= 1'b0;
      err_o   <= 1'b0;
      rdata_o <= '0;
    end
    else
    begin
      ack_o   <= |ch_ack_i;
      err_o   <= err_i;                        // unmapped slot
      rdata_o <= rdata_merged;                 // zero when nothing acks
    end
  end

endmodule

//--- design/uart_hub_top.sv
`timescale 1ns/1ns

module uart_hub_top (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                wb_cyc_i,
  input  logic                                wb_stb_i,
  input  logic                                wb_we_i,
  input  logic [uart_hub_pkg::ADDR_W-1:0]     wb_adr_i,
  input  logic [uart_hub_pkg::DATA_W-1:0]     wb_dat_i,
  output logic [uart_hub_pkg::DATA_W-1:0]     wb_dat_o,
  output logic                                wb_ack_o,
  output logic                                wb_err_o,
  output logic [uart_hub_pkg::N_CHANNELS-1:0] txd_o
);

  import uart_hub_pkg::*;

  logic [N_CHANNELS-1:0] ch_req;
  logic                  ch_we;
  reg_op_e               ch_op;
  logic [DATA_W-1:0]     ch_wdata;
  logic [N_CHANNELS-1:0] ch_ack;
  logic [DATA_W-1:0]     ch_rdata [N_CHANNELS];
  logic                  dec_err;
  logic                  bus_done;

  assign bus_done = wb_ack_o || wb_err_o;     // frees the decoder for the next cycle

  wb_addr_decoder wb_addr_decoder_inst (
    .clk        (clk),
    .rst        (rst),
    .cyc_i      (wb_cyc_i),
    .stb_i      (wb_stb_i),
    .we_i       (wb_we_i),
    .adr_i      (wb_adr_i),
    .wdata_i    (wb_dat_i),
    .done_i     (bus_done),
    .ch_req_o   (ch_req),
    .ch_we_o    (ch_we),
    .ch_op_o    (ch_op),
    .ch_wdata_o (ch_wdata),
    .err_o      (dec_err)
  );

  for (genvar i = 0; i < N_CHANNELS; i++)
  begin : gen_channel
    uart_tx_channel uart_tx_channel_inst (
      .clk     (clk),
      .rst     (rst),
      .req_i   (ch_req[i]),
      .we_i    (ch_we),
      .op_i    (ch_op),
      .wdata_i (ch_wdata),
      .ack_o   (ch_ack[i]),
      .rdata_o (ch_rdata[i]),
      .txd_o   (txd_o[i])
    );
  end

  wb_rsp_mux wb_rsp_mux_inst (
    .clk        (clk),
    .rst        (rst),
    .ch_ack_i   (ch_ack),
    .ch_rdata_i (ch_rdata),
    .err_i      (dec_err),
    .ack_o      (wb_ack_o),
    .err_o      (wb_err_o),
    .rdata_o    (wb_dat_o)
  );

endmodule

//--- dv/uart_line_model.svh
// expected frame: start, data LSB first, even parity, two stops
function automatic logic [FRAME_BITS-1:0] build_frame(input logic [7:0] data);
  logic [FRAME_BITS-1:0] frame;
  logic                  parity;
  parity = 1'b0;
  for (int i = 0; i < 8; i++)
    parity = parity ^ data[i];
  frame[0] = 1'b0;                             // start bit
  for (int i = 0; i < 8; i++)
    frame[1 + i] = data[i];
  frame[9]  = parity;
  frame[10] = 1'b1;
  frame[11] = 1'b1;
  return frame;
endfunction

// follows one line from its start bit to the end of the second stop bit
task automatic expect_frame(input int ch, input logic [7:0] data, input int div);
  logic [FRAME_BITS-1:0] frame;
  logic [N_CHANNELS-1:0] others;
  int                    wait_cycles;
  frame       = build_frame(data);
  wait_cycles = 0;
  while (txd[ch] !== 1'b0)
  begin
    @(posedge clk);
    #1;
    wait_cycles++;
    if (wait_cycles > 4)
      abort_run($sformatf("no start bit appeared on txd_o[%0d]", ch));
  end
  // every cycle of a bit is compared, the middle included, so a bit
  // that is shorter or longer than div+1 cycles shows up as a mismatch
  for (int b = 0; b < FRAME_BITS; b++)
  begin
    for (int c = 0; c <= div; c++)
    begin
      check_value($sformatf("txd_o[%0d] bit %0d", ch, b), txd[ch], frame[b]);
      others     = txd;
      others[ch] = 1'b1;
      check_value("txd_o other lines", others, {N_CHANNELS{1'b1}});
      @(posedge clk);
      #1;
    end
  end
  check_value($sformatf("txd_o[%0d] after frame", ch), txd[ch], 1'b1);
endtask

//--- dv/uart_hub_tb.sv
`timescale 1ns/1ns

module uart_hub_tb;

  import uart_hub_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int N_FRAMES   = 40;
  localparam int MIN_DIV    = 2;
  localparam int MAX_DIV    = 9;
  localparam int REG_CYCLES = 3;              // stb sampled to wb_ack_o
  localparam int ERR_CYCLES = 2;              // stb sampled to wb_err_o
  localparam int MAX_WAIT   = REG_CYCLES + FRAME_BITS * (MAX_DIV + 1) + 8;

  // margin covers reset and register traffic
  localparam longint MARGIN_CYCLES = 5000;
  localparam longint TIMEOUT_NS =
    (longint'(N_FRAMES) * FRAME_BITS * (MAX_DIV + 1) + MARGIN_CYCLES) * CLK_PERIOD;

  logic                  clk;
  logic                  rst;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  logic [ADDR_W-1:0]     wb_adr;
  logic [DATA_W-1:0]     wb_dat_w;
  logic [DATA_W-1:0]     wb_dat_r;
  logic                  wb_ack;
  logic                  wb_err;
  logic [N_CHANNELS-1:0] txd;

  integer                seed;
  logic [DIVIDER_W-1:0]  div_model [N_CHANNELS];

  uart_hub_top uart_hub_top_inst (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w),
    .wb_dat_o (wb_dat_r),
    .wb_ack_o (wb_ack),
    .wb_err_o (wb_err),
    .txd_o    (txd)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("[ERROR] %0t ns %s: actual 0x%0h, expected 0x%0h",
               $time, name, actual, expected);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  `include "uart_line_model.svh"

  function automatic int rand_range(input int lo, input int hi);
    return lo + ($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  function automatic logic [ADDR_W-1:0] reg_addr(input int slot, input logic [1:0] offset);
    logic [ADDR_W-1:0] adr;
    adr                        = '0;
    adr[CH_SEL_LO +: CH_SEL_W] = slot[CH_SEL_W-1:0];
    adr[3:2]                   = offset;
    return adr;
  endfunction

  // starts and returns 2 ns after a rising edge
  task automatic bus_cycle(
    input  logic                  we,
    input  logic [ADDR_W-1:0]     adr,
    input  logic [DATA_W-1:0]     wdata,
    output logic [DATA_W-1:0]     rdata,
    output logic                  ack,
    output logic                  err,
    output int                    cycles,
    output logic [N_CHANNELS-1:0] line_low
  );
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    ack      = 1'b0;
    err      = 1'b0;
    cycles   = 0;
    rdata    = '0;
    line_low = '0;
    while (!ack && !err)
    begin
      @(posedge clk);
      #1;
      cycles++;
      line_low = line_low | ~txd;
      ack      = wb_ack;
      err      = wb_err;
      rdata    = wb_dat_r;
      if (cycles > MAX_WAIT)
        abort_run($sformatf("bus access to 0x%0h got neither ack nor err", adr));
    end
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(posedge clk);                            // no new access in the cycle after the response
    #2;
  endtask

  task automatic register_access(input logic we, input int slot, input logic [1:0] offset,
                                 input logic [DATA_W-1:0] wdata,
                                 input logic [DATA_W-1:0] exp_rdata);
    logic [DATA_W-1:0]     rdata;
    logic                  ack;
    logic                  err;
    int                    cycles;
    logic [N_CHANNELS-1:0] line_low;
    bus_cycle(we, reg_addr(slot, offset), wdata, rdata, ack, err, cycles, line_low);
    check_value("wb_ack_o", ack, 1'b1);
    check_value("wb_err_o", err, 1'b0);
    check_value("wb_ack_o latency", cycles, REG_CYCLES);
    check_value("txd_o low during access", line_low, '0);
    if (!we)
      check_value("wb_dat_o", rdata, exp_rdata);
  endtask

  task automatic unmapped_access(input logic we, input int slot, input logic [1:0] offset);
    logic [DATA_W-1:0]     rdata;
    logic                  ack;
    logic                  err;
    int                    cycles;
    logic [N_CHANNELS-1:0] line_low;
    bus_cycle(we, reg_addr(slot, offset), $random(seed), rdata, ack, err, cycles, line_low);
    check_value("wb_err_o", err, 1'b1);
    check_value("wb_ack_o", ack, 1'b0);
    check_value("wb_err_o latency", cycles, ERR_CYCLES);
    check_value("txd_o low during access", line_low, '0);
  endtask

  // upper bits random since only the low 16 hold the divider
  task automatic set_divider(input int ch, input int div);
    logic [DATA_W-1:0] wdata;
    wdata = {16'($random(seed)), 16'(div)};
    register_access(1'b1, ch, REG_DIVIDER, wdata, '0);
    div_model[ch] = 16'(div);
    register_access(1'b0, ch, REG_DIVIDER, '0, {16'h0, div_model[ch]});
  endtask

  task automatic send_frame(input int ch, input logic [7:0] data);
    logic [DATA_W-1:0]     rdata;
    logic                  ack;
    logic                  err;
    int                    cycles;
    logic [N_CHANNELS-1:0] line_low;
    bus_cycle(1'b1, reg_addr(ch, REG_DATA), {24'($random(seed)), data},
              rdata, ack, err, cycles, line_low);
    check_value("wb_ack_o", ack, 1'b1);
    check_value("wb_err_o", err, 1'b0);
    // ack one mux cycle after the second stop bit ends
    check_value("wb_ack_o latency", cycles,
                REG_CYCLES + FRAME_BITS * (int'(div_model[ch]) + 1));
  endtask

  initial
  begin
    #(TIMEOUT_NS);
    abort_run("simulation timed out before all tests finished");
  end

  initial
  begin
    int         ch;
    logic [7:0] data;
    seed     = 32'h932f_0948;
    rst      = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;

    // reset state
    check_value("txd_o", txd, {N_CHANNELS{1'b1}});
    check_value("wb_ack_o", wb_ack, 1'b0);
    check_value("wb_err_o", wb_err, 1'b0);
    check_value("wb_dat_o", wb_dat_r, '0);
    for (int i = 0; i < N_CHANNELS; i++)
    begin
      div_model[i] = DEFAULT_DIVIDER;
      register_access(1'b0, i, REG_DIVIDER, '0, {16'h0, DEFAULT_DIVIDER});
    end

    for (int round = 0; round < 2; round++)
      for (int i = 0; i < N_CHANNELS; i++)
        set_divider(i, rand_range(MIN_DIV, MAX_DIV));

    // unused offsets and data reads return zero and writes leave the divider alone
    for (int i = 0; i < N_CHANNELS; i++)
    begin
      register_access(1'b0, i, REG_DATA, '0, '0);
      register_access(1'b0, i, 2'd2, '0, '0);
      register_access(1'b0, i, 2'd3, '0, '0);
      register_access(1'b1, i, 2'd2, $random(seed), '0);
      register_access(1'b1, i, 2'd3, $random(seed), '0);
      register_access(1'b0, i, REG_DIVIDER, '0, {16'h0, div_model[i]});
    end

    for (int slot = N_CHANNELS; slot < (1 << CH_SEL_W); slot++)
    begin
      unmapped_access(1'b1, slot, 2'(rand_range(0, 3)));
      unmapped_access(1'b0, slot, 2'(rand_range(0, 3)));
    end

    for (int n = 0; n < N_FRAMES; n++)
    begin
      if (n == N_FRAMES / 2)
        for (int i = 0; i < N_CHANNELS; i++)
          set_divider(i, rand_range(MIN_DIV, MAX_DIV));
      ch   = rand_range(0, N_CHANNELS - 1);
      data = 8'(rand_range(0, 255));
      fork
        send_frame(ch, data);
        expect_frame(ch, data, int'(div_model[ch]));
      join
    end

    check_value("txd_o", txd, {N_CHANNELS{1'b1}});
    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- uart_hub.f
+incdir+dv
design/uart_hub_pkg.sv
design/wb_addr_decoder.sv
design/uart_tx_channel.sv
design/wb_rsp_mux.sv
design/uart_hub_top.sv
dv/uart_hub_tb.sv

//--- Bender.yml
package:
  name: uart_hub

sources:
  - files:
      - design/uart_hub_pkg.sv
      - design/wb_addr_decoder.sv
      - design/uart_tx_channel.sv
      - design/wb_rsp_mux.sv
      - design/uart_hub_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/uart_hub_tb.sv
